//--- Bender.yml
package:
  name: dual_issue

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/issue_pkg.sv
      - hdl/inst_queue.sv
      - hdl/inst_decoder.sv
      - hdl/load_track.sv
      - hdl/issue_ctrl.sv
      - hdl/dual_issue_unit.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/tb_dual_issue_unit.sv

//--- dual_issue.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/issue_pkg.sv
hdl/inst_queue.sv
hdl/inst_decoder.sv
hdl/load_track.sv
hdl/issue_ctrl.sv
hdl/dual_issue_unit.sv
dv/tb_dual_issue_unit.sv

//--- dv/tb_dual_issue_unit.sv
`include "mips_isa_defs.svh"

module tb_dual_issue_unit import issue_pkg::*; ();

    // flags are {no pairing as master, never a slave, branch, load}
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  src_a;
        logic [4:0]  src_b;
        logic [4:0]  dst;
        logic [3:0]  flags;
    } tinst_t;

    logic        clk;
    logic        rst_n;
    fetch_pair_t fetch;
    logic        fetch_full;
    issue_slot_t issue_master;
    issue_slot_t issue_slave;
    logic        slave_in_delayslot;

    tinst_t      exp_q[$];
    tinst_t      pend0;
    tinst_t      pend1;
    logic        e_v = 1'b0;
    logic        m_v = 1'b0;
    logic [4:0]  e_dst = '0;
    logic [4:0]  m_dst = '0;
    logic [31:0] next_pc = 32'h0000_1000;
    string       cur_test = "reset";
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_issued;
    int          n_dual;
    int          n_delay;
    int          n_stall;
    int          n_lost;
    int          n_full;

    dual_issue_unit dut0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .fetch              (fetch),
        .fetch_full         (fetch_full),
        .issue_master       (issue_master),
        .issue_slave        (issue_slave),
        .slave_in_delayslot (slave_in_delayslot)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic tinst_t make_inst(input logic [31:0] instr, input logic [4:0] a, b, d,
                                         input logic [3:0] flags);
        return '{pc: 32'h0, instr: instr, src_a: a, src_b: b, dst: d, flags: flags};
    endfunction

    function automatic tinst_t addu(input logic [4:0] rd, rs, rt);
        return make_inst({6'h00, rs, rt, rd, 5'h00, 6'h21}, rs, rt, rd, 4'b0000);
    endfunction

    function automatic tinst_t addiu(input logic [4:0] rt, rs);
        return make_inst({6'h09, rs, rt, 16'h0010}, rs, 5'd0, rt, 4'b0000);
    endfunction

    function automatic tinst_t lw(input logic [4:0] rt, base);
        return make_inst({6'h23, base, rt, 16'h0000}, base, 5'd0, rt, 4'b1101);
    endfunction

    function automatic tinst_t sw(input logic [4:0] rt, base);
        return make_inst({6'h2b, base, rt, 16'h0000}, base, rt, 5'd0, 4'b1100);
    endfunction

    function automatic tinst_t mult(input logic [4:0] rs, rt);
        return make_inst({6'h00, rs, rt, 10'h000, 6'h18}, rs, rt, 5'd0, 4'b0100);
    endfunction

    function automatic tinst_t mflo(input logic [4:0] rd);
        return make_inst({16'h0000, rd, 5'h00, 6'h12}, 5'd0, 5'd0, rd, 4'b0100);
    endfunction

    function automatic tinst_t syscall();
        return make_inst({26'h0, 6'h0c}, 5'd0, 5'd0, 5'd0, 4'b1100);
    endfunction

    function automatic tinst_t mfc0(input logic [4:0] rt, rd);
        return make_inst({6'h10, 5'h00, rt, rd, 11'h000}, 5'd0, 5'd0, rt, 4'b1100);
    endfunction

    function automatic tinst_t beq(input logic [4:0] rs, rt);
        return make_inst({6'h04, rs, rt, 16'h0004}, rs, rt, 5'd0, 4'b0110);
    endfunction

    function automatic logic waits_on_load(input tinst_t t);
        return (e_v && (t.src_a == e_dst || t.src_b == e_dst)) ||
               (m_v && (t.src_a == m_dst || t.src_b == m_dst));
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    // reference step for the coming edge, run where the DUT outputs are settled
    task automatic model_step();
        tinst_t mst;
        tinst_t slv;
        logic   full;
        logic   exp_m;
        logic   exp_s;
        logic   exp_ds;
        mst   = '0;
        slv   = '0;
        full  = exp_q.size() > `IQ_DEPTH - 2;
        exp_m = 1'b0;
        exp_s = 1'b0;
        if (exp_q.size() > 0) begin
            mst   = exp_q[0];
            exp_m = !waits_on_load(mst);
        end
        if (exp_m && exp_q.size() > 1) begin
            slv   = exp_q[1];
            exp_s = !mst.flags[3] && !slv.flags[2] && !waits_on_load(slv) &&
                    !(mst.dst != '0 && (slv.src_a == mst.dst || slv.src_b == mst.dst));
        end
        exp_ds = exp_s && mst.flags[1];
        check("fetch_full", 64'(full), 64'(fetch_full));
        check("master valid", 64'(exp_m), 64'(issue_master.valid));
        check("slave valid", 64'(exp_s), 64'(issue_slave.valid));
        check("delay slot", 64'(exp_ds), 64'(slave_in_delayslot));
        if (exp_m) begin
            check("master slot", {mst.pc, mst.instr}, {issue_master.pc, issue_master.instr});
        end
        if (exp_s) begin
            check("slave slot", {slv.pc, slv.instr}, {issue_slave.pc, issue_slave.instr});
        end
        n_issued += int'(exp_m) + int'(exp_s);
        n_dual   += int'(exp_s);
        n_delay  += int'(exp_ds);
        n_stall  += int'(exp_q.size() > 0 && !exp_m);
        n_full   += int'(full);
        m_v   = e_v;
        m_dst = e_dst;
        e_v   = (exp_m && mst.flags[0]) || (exp_s && slv.flags[0]);
        e_dst = (exp_m && mst.flags[0]) ? mst.dst : slv.dst;
        if (exp_m) begin
            void'(exp_q.pop_front());
        end
        if (exp_s) begin
            void'(exp_q.pop_front());
        end
        if (fetch.valid == 2'b11 && full) begin
            n_lost += 2;
        end else if (fetch.valid == 2'b11) begin
            exp_q.push_back(pend0);
            exp_q.push_back(pend1);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            model_step();
        end
    end

    task automatic push_pair(input tinst_t a, input tinst_t b);
        @(posedge clk);
        a.pc = next_pc;
        b.pc = next_pc + 32'd4;
        next_pc = next_pc + 32'd8;
        fetch.valid  <= 2'b11;
        fetch.ent[0] <= '{pc: a.pc, instr: a.instr};
        fetch.ent[1] <= '{pc: b.pc, instr: b.instr};
        pend0 <= a;
        pend1 <= b;
    endtask

    task automatic stop_fetch();
        @(posedge clk);
        fetch.valid <= 2'b00;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        n_issued = 0;
        n_dual   = 0;
        n_delay  = 0;
        n_stall  = 0;
        n_lost   = 0;
        n_full   = 0;
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: %s did not complete in test %s", what, cur_test);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || fetch.valid != 2'b00) begin
            if (cycles == limit) begin
                timeout_abort("queue drain");
            end
            @(posedge clk);
            cycles++;
        end
        // lets the last load leave the memory stage
        repeat (3) @(posedge clk);
    endtask

    task automatic test_alu_pairs();
        start_test("alu_pairs");
        for (int i = 0; i < 3; i++) begin
            push_pair(addu(5'($urandom_range(19, 16)), 5'($urandom_range(15, 1)),
                           5'($urandom_range(15, 1))),
                      addiu(5'($urandom_range(19, 16)), 5'($urandom_range(15, 1))));
        end
        // a write to $0 is no dependency
        push_pair(addu(5'd0, 5'd1, 5'd2), addu(5'd16, 5'd0, 5'd0));
        // the rt field of an immediate slave is its destination, not a source
        push_pair(addu(5'd16, 5'd1, 5'd2), addiu(5'd16, 5'd3));
        stop_fetch();
        wait_drain(50);
        check("dual issues", 64'd5, 64'(n_dual));
        check("issued", 64'd10, 64'(n_issued));
    endtask

    task automatic test_no_pairing();
        start_test("no_pairing");
        push_pair(addu(5'd16, 5'd1, 5'd2), addu(5'd17, 5'd3, 5'd16));
        push_pair(lw(5'd20, 5'd5), addu(5'd18, 5'd6, 5'd7));
        push_pair(sw(5'd8, 5'd9), mult(5'd1, 5'd2));
        push_pair(mflo(5'd19), syscall());
        push_pair(mfc0(5'd12, 5'd12), addu(5'd13, 5'd1, 5'd2));
        push_pair(beq(5'd1, 5'd2), sw(5'd3, 5'd4));
        stop_fetch();
        wait_drain(60);
        check("dual issues", 64'd0, 64'(n_dual));
        check("issued", 64'd12, 64'(n_issued));
    endtask

    task automatic test_delay_slot();
        start_test("delay_slot");
        push_pair(beq(5'd1, 5'd2), addu(5'd21, 5'd3, 5'd4));
        push_pair(beq(5'd5, 5'd6), sw(5'd7, 5'd8));
        stop_fetch();
        wait_drain(50);
        check("delay slots", 64'd1, 64'(n_delay));
        check("dual issues", 64'd1, 64'(n_dual));
        check("issued", 64'd4, 64'(n_issued));
    endtask

    task automatic test_load_use();
        start_test("load_use");
        // the first consumer waits in the slave slot while the load is in execute
        push_pair(lw(5'd20, 5'd1), addu(5'd24, 5'd4, 5'd2));
        push_pair(addu(5'd25, 5'd20, 5'd3), addu(5'd26, 5'd4, 5'd5));
        push_pair(lw(5'd21, 5'd6), addu(5'd27, 5'd21, 5'd7));
        stop_fetch();
        wait_drain(50);
        check("stall cycles", 64'd3, 64'(n_stall));
        check("dual issues", 64'd1, 64'(n_dual));
        check("issued", 64'd6, 64'(n_issued));
    endtask

    task automatic test_fill_queue();
        start_test("fill_queue");
        // each instruction reads the one before it, so only one issues per cycle
        for (int i = 0; i < 8; i++) begin
            push_pair(addu(5'(16 + 2 * (i % 2)), 5'(19 - 2 * (i % 2)), 5'd1),
                      addu(5'(17 + 2 * (i % 2)), 5'(16 + 2 * (i % 2)), 5'd1));
        end
        stop_fetch();
        wait_drain(80);
        check("full seen", 64'd1, 64'(n_full > 0));
        check("pushes lost", 64'd1, 64'(n_lost > 0));
        check("issued", 64'(16 - n_lost), 64'(n_issued));
    endtask

    initial begin
        void'($urandom(37));
        fetch = '0;
        pend0 = '0;
        pend1 = '0;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_alu_pairs();
        test_no_pairing();
        test_delay_slot();
        test_load_use();
        test_fill_queue();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- hdl/dual_issue_unit.sv
module dual_issue_unit import isa_pkg::*, issue_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  fetch_pair_t fetch,
    output logic        fetch_full,
    output issue_slot_t issue_master,
    output issue_slot_t issue_slave,
    output logic        slave_in_delayslot
);

    iq_entry_t   head0;
    iq_entry_t   head1;
    logic        empty;
    logic        almost_empty;
    decoded_t    master_dec;
    decoded_t    slave_dec;
    load_stage_t e_load;
    load_stage_t m_load;
    logic        d_master_en;
    logic        d_slave_en;

    inst_queue iq0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch        (fetch),
        .pop_master   (d_master_en),
        .pop_slave    (d_slave_en),
        .head0        (head0),
        .head1        (head1),
        .empty        (empty),
        .almost_empty (almost_empty),
        .fetch_full   (fetch_full)
    );

    inst_decoder dec_master (
        .instr (head0.instr),
        .dec   (master_dec)
    );

    inst_decoder dec_slave (
        .instr (head1.instr),
        .dec   (slave_dec)
    );

    load_track ltrack0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .master_dec   (master_dec),
        .slave_dec    (slave_dec),
        .empty        (empty),
        .slave_issued (d_slave_en),
        .d_master_en  (d_master_en),
        .e_load       (e_load),
        .m_load       (m_load)
    );

    issue_ctrl ictrl0 (
        .d_master_en             (d_master_en),
        .master_dec              (master_dec),
        .slave_dec               (slave_dec),
        .e_load                  (e_load),
        .m_load                  (m_load),
        .fifo_empty              (empty),
        .fifo_almost_empty       (almost_empty),
        .d_slave_en              (d_slave_en),
        .d_slave_is_in_delayslot (slave_in_delayslot)
    );

    assign issue_master = '{valid: d_master_en, pc: head0.pc, instr: head0.instr};
    assign issue_slave  = '{valid: d_slave_en, pc: head1.pc, instr: head1.instr};

endmodule

//--- hdl/inst_decoder.sv
`include "mips_isa_defs.svh"

module inst_decoder import isa_pkg::*; (
    input  logic [31:0] instr,
    output decoded_t    dec
);

    // link register of jal, jalr and the regimm link branches
    localparam logic [`REG_ADDR_W-1:0] REG_RA = '1;

    opcode_e                op;
    logic [5:0]             funct;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   is_muldiv;

    assign op    = opcode_e'(instr[31:26]);
    assign funct = instr[5:0];
    assign rd    = instr[15:11];

    // mult, multu, div and divu
    assign is_muldiv = ({funct[5:1], 1'b0} == `FUNCT_MULT) ||
                       ({funct[5:1], 1'b0} == `FUNCT_DIV);

    always_comb begin
        dec     = '0;
        dec.op  = op;
        dec.rs  = instr[25:21];
        dec.rt  = instr[20:16];
        dec.cls = CLS_ALU;
        case (op)
            OP_SPECIAL: begin
                dec.reg_waddr = rd;
                dec.reg_wen   = 1'b1;
                if (is_muldiv) begin
                    dec.reg_wen           = 1'b0;
                    dec.is_only_in_master = 1'b1;
                    dec.cls               = CLS_MULDIV;
                end else if (funct == `FUNCT_MFHI || funct == `FUNCT_MFLO) begin
                    dec.is_only_in_master = 1'b1;
                    dec.cls               = CLS_MULDIV;
                end else if (funct == `FUNCT_MTHI || funct == `FUNCT_MTLO) begin
                    dec.reg_wen           = 1'b0;
                    dec.is_only_in_master = 1'b1;
                    dec.cls               = CLS_MULDIV;
                end else if (funct == `FUNCT_SYSCALL || funct == `FUNCT_BREAK) begin
                    dec.reg_wen      = 1'b0;
                    dec.is_spec_inst = 1'b1;
                    dec.cls          = CLS_COP0;
                end else if (funct == `FUNCT_JR || funct == `FUNCT_JALR) begin
                    // jr writes nothing, jalr links into rd
                    dec.reg_wen   = (funct == `FUNCT_JALR);
                    dec.is_branch = 1'b1;
                    dec.cls       = CLS_BRANCH;
                end
            end
            OP_REGIMM: begin
                // bltzal and bgezal have bit 20 set
                dec.reg_wen   = instr[20];
                dec.reg_waddr = REG_RA;
                dec.is_branch = 1'b1;
                dec.cls       = CLS_BRANCH;
            end
            OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                dec.is_branch = 1'b1;
                dec.cls       = CLS_BRANCH;
            end
            OP_JAL: begin
                dec.reg_wen   = 1'b1;
                dec.reg_waddr = REG_RA;
                dec.is_branch = 1'b1;
                dec.cls       = CLS_BRANCH;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.reg_wen   = 1'b1;
                dec.reg_waddr = dec.rt;
            end
            OP_COP0: begin
                // only mfc0 (rs field zero) writes a general register
                dec.reg_wen      = (dec.rs == '0);
                dec.reg_waddr    = dec.rt;
                dec.is_spec_inst = 1'b1;
                dec.cls          = CLS_COP0;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                dec.reg_wen    = 1'b1;
                dec.reg_waddr  = dec.rt;
                dec.mem_en     = 1'b1;
                dec.mem_to_reg = 1'b1;
                dec.cls        = CLS_LOAD;
            end
            OP_SB, OP_SH, OP_SW: begin
                dec.mem_en = 1'b1;
                dec.cls    = CLS_STORE;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/inst_queue.sv
`include "mips_isa_defs.svh"

module inst_queue import issue_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  fetch_pair_t fetch,
    input  logic        pop_master,
    input  logic        pop_slave,
    output iq_entry_t   head0,
    output iq_entry_t   head1,
    output logic        empty,
    output logic        almost_empty,
    output logic        fetch_full
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    iq_entry_t        mem [`IQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic [1:0]       push_num;
    logic [1:0]       pop_num;

    // the whole pair is refused unless two slots are free
    assign push_ok  = !fetch_full;
    assign push_num = push_ok ? 2'(fetch.valid[0]) + 2'(fetch.valid[1]) : 2'd0;
    assign pop_num  = 2'(pop_master) + 2'(pop_slave);

    assign rd_ptr_nxt = rd_ptr + PTR_W'(1);
    // entry 1 follows entry 0 only when entry 0 is actually written
    assign wr_ptr_nxt = wr_ptr + PTR_W'(fetch.valid[0]);

    always_ff @(posedge clk) begin
        if (push_ok && fetch.valid[0]) begin
            mem[wr_ptr] <= fetch.ent[0];
        end
        if (push_ok && fetch.valid[1]) begin
            mem[wr_ptr_nxt] <= fetch.ent[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_num);
            wr_ptr <= wr_ptr + PTR_W'(push_num);
            count  <= count + CNT_W'(push_num) - CNT_W'(pop_num);
        end
    end

    assign head0 = mem[rd_ptr];
    assign head1 = mem[rd_ptr_nxt];

    assign empty        = (count == '0);
    assign almost_empty = (count == CNT_W'(1));
    assign fetch_full   = (count > CNT_W'(`IQ_DEPTH - 2));

    // the issue side must only pop what the queue reports as present
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop_master |-> !empty
    );

    a_slave_after_master: assert property (
        @(posedge clk) disable iff (!rst_n) pop_slave |-> (pop_master && !almost_empty)
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n) count <= CNT_W'(`IQ_DEPTH)
    );

endmodule

//--- hdl/isa_pkg.sv
`include "mips_isa_defs.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = `OP_SPECIAL_INST,
        OP_REGIMM  = `OP_REGIMM,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_COP0    = `OP_COP0,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_MULDIV,
        CLS_COP0
    } inst_class_e;

    typedef struct packed {
        opcode_e                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] reg_waddr;
        logic                   reg_wen;
        logic                   mem_en;
        logic                   mem_to_reg;
        logic                   is_branch;
        logic                   is_spec_inst;
        logic                   is_only_in_master;
        inst_class_e            cls;
    } decoded_t;

endpackage

//--- hdl/issue_ctrl.sv
module issue_ctrl import isa_pkg::*, issue_pkg::*; (
    input  logic        d_master_en,
    input  decoded_t    master_dec,
    input  decoded_t    slave_dec,
    input  load_stage_t e_load,
    input  load_stage_t m_load,
    input  logic        fifo_empty,
    input  logic        fifo_almost_empty,
    output logic        d_slave_en,
    output logic        d_slave_is_in_delayslot
);

    logic pair_ok;
    logic fifo_ok;
    logic load_stall;

    // the slave needs a second valid entry behind the master
    assign fifo_ok = !(fifo_empty || fifo_almost_empty);

    assign load_stall = load_use_hit(e_load, slave_dec.rs, slave_dec.rt) ||
                        load_use_hit(m_load, slave_dec.rs, slave_dec.rt);

    always_comb begin
        if (!d_master_en || master_dec.mem_en || master_dec.is_spec_inst ||
            slave_dec.is_branch || slave_dec.mem_en || slave_dec.is_spec_inst ||
            slave_dec.is_only_in_master) begin
            pair_ok = 1'b0;
        end else if (master_dec.reg_wen && master_dec.reg_waddr != '0) begin
            // rt is a source only for register-format slaves
            if (slave_dec.op == OP_SPECIAL) begin
                pair_ok = (slave_dec.rs != master_dec.reg_waddr) &&
                          (slave_dec.rt != master_dec.reg_waddr);
            end else begin
                pair_ok = (slave_dec.rs != master_dec.reg_waddr);
            end
        end else begin
            pair_ok = 1'b1;
        end
    end

    assign d_slave_en              = pair_ok && fifo_ok && !load_stall;
    assign d_slave_is_in_delayslot = master_dec.is_branch && d_slave_en;

endmodule

//--- hdl/issue_pkg.sv
`include "mips_isa_defs.svh"

package issue_pkg;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } iq_entry_t;

    // entry 0 is the older instruction of the pair
    typedef struct packed {
        logic [1:0]      valid;
        iq_entry_t [1:0] ent;
    } fetch_pair_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } issue_slot_t;

    // a load sitting in the execute or memory stage
    typedef struct packed {
        logic                   mem_to_reg;
        logic [`REG_ADDR_W-1:0] reg_waddr;
    } load_stage_t;

    // true when either source register waits on the load held in st
    function automatic logic load_use_hit(
        input load_stage_t            st,
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`REG_ADDR_W-1:0] rt
    );
        return st.mem_to_reg && (rs == st.reg_waddr || rt == st.reg_waddr);
    endfunction

endpackage

//--- hdl/load_track.sv
module load_track import isa_pkg::*, issue_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  decoded_t    master_dec,
    input  decoded_t    slave_dec,
    input  logic        empty,
    input  logic        slave_issued,
    output logic        d_master_en,
    output load_stage_t e_load,
    output load_stage_t m_load
);

    logic        master_is_load;
    logic        slave_is_load;
    load_stage_t e_load_nxt;

    // the master waits while a load ahead of it has not returned its data
    assign d_master_en = !empty &&
                         !load_use_hit(e_load, master_dec.rs, master_dec.rt) &&
                         !load_use_hit(m_load, master_dec.rs, master_dec.rt);

    // a load into $0 leaves nothing to wait for
    assign master_is_load = d_master_en && master_dec.mem_to_reg && master_dec.reg_waddr != '0;
    assign slave_is_load  = slave_issued && slave_dec.mem_to_reg && slave_dec.reg_waddr != '0;

    always_comb begin
        e_load_nxt = '0;
        if (master_is_load) begin
            e_load_nxt = '{mem_to_reg: 1'b1, reg_waddr: master_dec.reg_waddr};
        end else if (slave_is_load) begin
            e_load_nxt = '{mem_to_reg: 1'b1, reg_waddr: slave_dec.reg_waddr};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_load <= '0;
            m_load <= '0;
        end else begin
            e_load <= e_load_nxt;
            m_load <= e_load;
        end
    end

    // the pairing rules keep a second load out of the slave slot
    a_one_load: assert property (
        @(posedge clk) disable iff (!rst_n) !(master_is_load && slave_is_load)
    );

endmodule

//--- hdl/mips_isa_defs.svh
`ifndef MIPS_ISA_DEFS_SVH
`define MIPS_ISA_DEFS_SVH

// primary opcode values that need special handling in decode
`define OP_SPECIAL_INST 6'b000000
`define OP_REGIMM       6'b000001
`define OP_COP0         6'b010000

// funct field values of the SPECIAL format
`define FUNCT_JR        6'b001000
`define FUNCT_JALR      6'b001001
`define FUNCT_SYSCALL   6'b001100
`define FUNCT_BREAK     6'b001101
`define FUNCT_MFHI      6'b010000
`define FUNCT_MTHI      6'b010001
`define FUNCT_MFLO      6'b010010
`define FUNCT_MTLO      6'b010011

// the unsigned variants differ only in bit 0
`define FUNCT_MULT      6'b011000
`define FUNCT_DIV       6'b011010

// instruction queue depth, kept a power of two so the pointers wrap naturally
`define IQ_DEPTH        8

`define REG_ADDR_W      5

`endif
